// File: design/pt2262_symbol_pkg.sv
`default_nettype none

package pt2262_symbol_pkg;

    // Frame layout
    localparam int ADDR_PINS         = 8;              // A0 to A7
    localparam int DATA_BITS         = 4;              // D3 down to D0
    localparam int SYMBOLS_PER_FRAME = ADDR_PINS + DATA_BITS + 1; // Twelve symbols plus sync
    localparam int PIN_CODE_BITS     = 2;              // Bits per tri-state pin

    // The four symbols as the sequencer names them
    typedef enum logic [1:0] {
        sym_zero  = 2'b00,
        sym_one   = 2'b01,
        sym_float = 2'b10,
        sym_sync  = 2'b11
    } symbol_kind_t;

    // Same two bits as the shaper reads them
    typedef struct packed {
        logic special; // Set for F and sync
        logic level;   // Zero or one, or float or sync when special
    } symbol_fields_t;

    // One symbol word, two decodes
    typedef union packed {
        symbol_kind_t   kind;
        symbol_fields_t fields;
    } symbol_word_t;

    // Pin encodings, either code with the high bit set floats
    typedef enum logic [1:0] {
        pin_zero  = 2'b00,
        pin_one   = 2'b01,
        pin_float = 2'b10
    } pin_code_t;

endpackage

`default_nettype wire

// File: design/pt2262_timing_pkg.sv
`default_nettype none

package pt2262_timing_pkg;

    // Pulse widths in alpha units
    localparam int SHORT_SLOTS = 4;
    localparam int LONG_SLOTS  = 12;

    // One half of a data symbol, one high pulse and one low gap
    localparam int HALF_SYMBOL_SLOTS = SHORT_SLOTS + LONG_SLOTS;

    // Whole symbol lengths
    localparam int DATA_SYMBOL_SLOTS = 2 * HALF_SYMBOL_SLOTS; // 32 alpha
    localparam int SYNC_SYMBOL_SLOTS = 128;                    // 4 high, 124 low

    // Slot counter width, sized by the longest symbol
    localparam int SLOT_BITS = $clog2(SYNC_SYMBOL_SLOTS);

endpackage

`default_nettype wire

// File: design/tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int DIVIDER = 250 // clk cycles per alpha
) (
    input  wire  clk,
    input  wire  reset,
    output logic tick
);

    localparam int CNT_BITS = (DIVIDER > 2) ? $clog2(DIVIDER) : 1;
    localparam logic [CNT_BITS-1:0] LAST_COUNT = CNT_BITS'(DIVIDER - 1);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count == LAST_COUNT) begin
            count <= '0;                   // Wrap, one alpha elapsed
        end else begin
            count <= count + 1'b1;
        end
    end

    // One cycle strobe on the wrap, low after reset since count starts at 0
    assign tick = (count == LAST_COUNT);

endmodule

`default_nettype wire

// File: design/address_interpreter.sv
`timescale 1ns/1ps
`default_nettype none

module address_interpreter import pt2262_symbol_pkg::*; (
    input  wire  [PIN_CODE_BITS*ADDR_PINS-1:0] addr_code,  // Two bits per pin, pin 0 lowest
    output logic [ADDR_PINS-1:0]               addr_level,
    output logic [ADDR_PINS-1:0]               addr_float
);

    pin_code_t pin_code [ADDR_PINS];

    // Split the word into one code per pin
    always_comb begin
        for (int i = 0; i < ADDR_PINS; i++) begin
            pin_code[i] = pin_code_t'(addr_code[PIN_CODE_BITS*i +: PIN_CODE_BITS]);
        end
    end

    always_comb begin
        for (int i = 0; i < ADDR_PINS; i++) begin
            // High bit set floats, low bit is then a don't care
            addr_float[i] = pin_code[i][1];
            // Level only meaningful for a driven pin
            addr_level[i] = (pin_code[i] == pin_one);
        end
    end

endmodule

`default_nettype wire

// File: design/symbol_shaper.sv
`timescale 1ns/1ps
`default_nettype none

module symbol_shaper import pt2262_symbol_pkg::*, pt2262_timing_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire               tick,          // One alpha strobe
    input  wire               symbol_start,  // Restart the slot counter
    input  wire symbol_word_t symbol,        // Read through the fields view
    output logic              line,          // Registered waveform
    output logic              symbol_done    // Tick closing the last slot
);

    localparam logic [SLOT_BITS-1:0] SHORT_W    = SLOT_BITS'(SHORT_SLOTS);
    localparam logic [SLOT_BITS-1:0] LONG_W     = SLOT_BITS'(LONG_SLOTS);
    localparam logic [SLOT_BITS-1:0] HALF_W     = SLOT_BITS'(HALF_SYMBOL_SLOTS);
    localparam logic [SLOT_BITS-1:0] DATA_LAST  = SLOT_BITS'(DATA_SYMBOL_SLOTS - 1);
    localparam logic [SLOT_BITS-1:0] SYNC_LAST  = SLOT_BITS'(SYNC_SYMBOL_SLOTS - 1);

    logic [SLOT_BITS-1:0] slot;      // Slot currently on the line
    logic                 active;    // A symbol is being shaped
    logic                 is_sync;
    logic [SLOT_BITS-1:0] last_slot;

    // Line level for one slot of a symbol
    function automatic logic slot_level(input logic [SLOT_BITS-1:0] slot_idx,
                                        input symbol_fields_t f);
        logic [SLOT_BITS-1:0] first_high;
        logic [SLOT_BITS-1:0] second_high;
        first_high  = (!f.special && f.level) ? LONG_W : SHORT_W; // Long only for a one
        second_high = (f.special || f.level) ? LONG_W : SHORT_W;  // Long for one and F
        if (f.special && f.level) begin
            return slot_idx < SHORT_W;                             // Sync, short pulse then gap
        end else if (slot_idx < HALF_W) begin
            return slot_idx < first_high;
        end else begin
            return (slot_idx - HALF_W) < second_high;
        end
    endfunction

    assign is_sync   = symbol.fields.special & symbol.fields.level;
    assign last_slot = is_sync ? SYNC_LAST : DATA_LAST;

    // Coincides with the tick that closes the final slot
    assign symbol_done = tick & active & (slot == last_slot);

    always_ff @(posedge clk) begin
        if (reset) begin
            slot   <= '0;
            active <= 1'b0;
            line   <= 1'b0;
        end else if (symbol_start) begin
            slot   <= '0;
            active <= 1'b1;
            // Every symbol opens high, so the word still held here is not needed
            line   <= 1'b1;
        end else if (tick && active) begin
            if (slot == last_slot) begin
                active <= 1'b0;                             // No follow-up symbol, go quiet
                line   <= 1'b0;
            end else begin
                slot   <= slot + 1'b1;
                line   <= slot_level(slot + 1'b1, symbol.fields); // Level of the slot ahead
            end
        end
    end

endmodule

`default_nettype wire

// File: design/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import pt2262_symbol_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  tick,
    input  wire  [ADDR_PINS-1:0] addr_level,
    input  wire  [ADDR_PINS-1:0] addr_float,
    input  wire  [DATA_BITS-1:0] data,
    input  wire                  symbol_done,
    output symbol_word_t         symbol,        // Held for the whole symbol
    output logic                 symbol_start,  // Same cycle as the opening tick
    output logic                 in_sync
);

    localparam int POS_BITS = $clog2(SYMBOLS_PER_FRAME);
    localparam logic [POS_BITS-1:0] LAST_POS = POS_BITS'(SYMBOLS_PER_FRAME - 1);

    typedef enum logic {
        st_idle,
        st_run
    } seq_state_t;

    seq_state_t           state;
    logic [POS_BITS-1:0]  pos;          // 0 to 7 address, 8 to 11 data, 12 sync
    logic [POS_BITS-1:0]  next_pos;
    logic                 advance;
    logic                 wrap;         // Next symbol is A0
    logic [ADDR_PINS-1:0] level_q;      // Inputs sampled at frame start
    logic [ADDR_PINS-1:0] float_q;
    logic [DATA_BITS-1:0] data_q;
    logic [ADDR_PINS-1:0] src_level;
    logic [ADDR_PINS-1:0] src_float;
    logic [DATA_BITS-1:0] src_data;
    symbol_word_t         next_symbol;

    // Symbol for one frame position
    function automatic symbol_word_t pick_symbol(input logic [POS_BITS-1:0] p,
                                                 input logic [ADDR_PINS-1:0] lvl,
                                                 input logic [ADDR_PINS-1:0] flt,
                                                 input logic [DATA_BITS-1:0] d);
        symbol_word_t w;
        int           idx;
        idx = int'(p);
        if (idx < ADDR_PINS) begin
            if (flt[idx]) begin
                w.kind = sym_float;                       // Floating pin wins
            end else begin
                w.kind = lvl[idx] ? sym_one : sym_zero;
            end
        end else if (idx < ADDR_PINS + DATA_BITS) begin
            idx    = ADDR_PINS + DATA_BITS - 1 - idx;     // D3 goes out first
            w.kind = d[idx] ? sym_one : sym_zero;
        end else begin
            w.kind = sym_sync;
        end
        return w;
    endfunction

    // First tick out of idle, then each symbol end
    assign advance      = tick && ((state == st_idle) || symbol_done);
    assign symbol_start = advance;
    assign wrap         = (state == st_idle) || (pos == LAST_POS);
    assign next_pos     = wrap ? '0 : pos + 1'b1;

    // A0 is picked from the live inputs, the rest from the sampled copy
    assign src_level   = wrap ? addr_level : level_q;
    assign src_float   = wrap ? addr_float : float_q;
    assign src_data    = wrap ? data : data_q;
    assign next_symbol = pick_symbol(next_pos, src_level, src_float, src_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            pos         <= '0;
            symbol.kind <= sym_zero;
        end else if (advance) begin
            state  <= st_run;
            pos    <= next_pos;
            symbol <= next_symbol;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && wrap) begin
            level_q <= addr_level; // Mid-frame changes wait for the next A0
            float_q <= addr_float;
            data_q  <= data;
        end
    end

    // Symbol and line change on the same edge, so this lines up with the sync pulse
    assign in_sync = (state == st_run) && (symbol.kind == sym_sync);

endmodule

`default_nettype wire

// File: design/pt2262_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module pt2262_encoder_top import pt2262_symbol_pkg::*; #(
    parameter int DIVIDER = 250 // 12 kHz alpha from a 3 MHz clk
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire  [PIN_CODE_BITS*ADDR_PINS-1:0] addr_code,  // Tri-state pin codes
    input  wire  [DATA_BITS-1:0]               data,
    output logic                               cod_o,      // Serial code line
    output logic                               sync        // Line during sync only
);

    logic                 tick;
    logic [ADDR_PINS-1:0] addr_level;
    logic [ADDR_PINS-1:0] addr_float;
    symbol_word_t         symbol;
    logic                 symbol_start;
    logic                 symbol_done;
    logic                 in_sync;
    logic                 line;

    tick_divider #(
        .DIVIDER (DIVIDER)
    ) i_tick_divider (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    // Combinational pin decode
    address_interpreter i_address_interpreter (
        .addr_code  (addr_code),
        .addr_level (addr_level),
        .addr_float (addr_float)
    );

    frame_sequencer i_frame_sequencer (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .addr_level   (addr_level),
        .addr_float   (addr_float),
        .data         (data),
        .symbol_done  (symbol_done),
        .symbol       (symbol),
        .symbol_start (symbol_start),
        .in_sync      (in_sync)
    );

    symbol_shaper i_symbol_shaper (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .symbol_start (symbol_start),
        .symbol       (symbol),
        .line         (line),
        .symbol_done  (symbol_done)
    );

    assign cod_o = line;
    assign sync  = line & in_sync; // Only the short sync pulse shows here

endmodule

`default_nettype wire

// File: bench/pt2262_encoder_props.sv
`timescale 1ns/1ps
`default_nettype none

module pt2262_encoder_props import pt2262_symbol_pkg::*; (
    input wire               clk,
    input wire               reset,
    input wire               tick,
    input wire               symbol_start,
    input wire               symbol_done,
    input wire symbol_word_t symbol,
    input wire               cod_o,
    input wire               sync
);

    logic started; // First symbol has been launched

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else if (symbol_start) begin
            started <= 1'b1;
        end
    end

    // Alpha strobe lasts one cycle only
    assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("tick stayed high for two consecutive cycles");

    // Once running, the word only moves after the shaper closes the symbol
    assert property (@(posedge clk) disable iff (reset)
                     started && !symbol_done |=> $stable(symbol))
        else $error("symbol changed before symbol_done");

    // Sync pulse opens and closes on a cod_o edge
    assert property (@(posedge clk) disable iff (reset) $changed(sync) |-> $changed(cod_o))
        else $error("sync changed without a matching cod_o edge");

    // Line is cleared by reset and stays low in the cycle after
    assert property (@(posedge clk) reset |=> !cod_o)
        else $error("cod_o high during or right after reset");

endmodule

bind pt2262_encoder_top pt2262_encoder_props i_pt2262_encoder_props (
    .clk          (clk),
    .reset        (reset),
    .tick         (tick),
    .symbol_start (symbol_start),
    .symbol_done  (symbol_done),
    .symbol       (symbol),
    .cod_o        (cod_o),
    .sync         (sync)
);

`default_nettype wire

// File: bench/pt2262_encoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pt2262_encoder_tb
    import pt2262_symbol_pkg::*, pt2262_timing_pkg::*;
();

    localparam int DIVIDER      = 4;               // Short alpha keeps the run fast
    localparam int RESET_CYCLES = 4;
    localparam int NUM_TABLE    = 8;
    localparam int NUM_RANDOM   = 4;
    localparam int NUM_ENTRIES  = NUM_TABLE + NUM_RANDOM;
    localparam int SWAP_POS     = 6;               // Mid-frame change lands in A6
    localparam int FRAME_TICKS  = (ADDR_PINS + DATA_BITS) * DATA_SYMBOL_SLOTS
                                  + SYNC_SYMBOL_SLOTS; // 512 alpha
    localparam int CYCLE_LIMIT  = (NUM_ENTRIES * 3 + 4) * FRAME_TICKS * DIVIDER;
    localparam logic [31:0] SEED = 32'hafd8_d05e;

    // Decoded symbol codes
    localparam int K_ZERO  = 0;
    localparam int K_ONE   = 1;
    localparam int K_FLOAT = 2;
    localparam int K_SYNC  = 3;
    localparam int K_BAD   = 4;

    // Directed entries, codes 10 and 11 both float
    localparam logic [15:0] TBL_ADDR [NUM_TABLE] = '{
        16'h0000, 16'h5555, 16'hAAAA, 16'hFFFF, 16'hB4E4, 16'h6C39, 16'h9254, 16'h0F50
    };
    localparam logic [3:0] TBL_DATA [NUM_TABLE] = '{
        4'h0, 4'hF, 4'h5, 4'hA, 4'h9, 4'h3, 4'hC, 4'h6
    };
    // Set entry swaps to the next one in the middle of its checked frame
    localparam bit TBL_SWAP [NUM_TABLE] = '{
        1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0
    };

    logic        clk;
    logic        reset;
    logic [15:0] addr_code;
    logic [3:0]  data;
    logic        cod_o;
    logic        sync;

    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          carry_hi;        // High sample already taken from the next pair
    int          carry_sync;
    logic [31:0] rng_state;

    pt2262_encoder_top #(
        .DIVIDER (DIVIDER)
    ) i_pt2262_encoder_top (
        .clk       (clk),
        .reset     (reset),
        .addr_code (addr_code),
        .data      (data),
        .cod_o     (cod_o),
        .sync      (sync)
    );

    always #5 clk = ~clk;

    // Hang guard sized from the number of entries
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d clock cycles without finishing the tests", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Symbol expected at a frame position, A0 first then D3 down to D0
    function automatic int expected_kind(input logic [15:0] a, input logic [3:0] d,
                                         input int pos);
        if (pos < ADDR_PINS) begin
            if (a[2*pos+1]) return K_FLOAT;        // High bit floats, low bit ignored
            return a[2*pos] ? K_ONE : K_ZERO;
        end else if (pos < ADDR_PINS + DATA_BITS) begin
            return d[ADDR_PINS + DATA_BITS - 1 - pos] ? K_ONE : K_ZERO;
        end
        return K_SYNC;
    endfunction

    function automatic string pos_name(input int pos);
        if (pos < ADDR_PINS) return $sformatf("A%0d", pos);
        if (pos < ADDR_PINS + DATA_BITS) return $sformatf("D%0d", ADDR_PINS + DATA_BITS - 1 - pos);
        return "sync";
    endfunction

    // Two high/low pairs in alpha units to a data symbol
    function automatic int classify_pairs(input int h1, input int l1, input int h2, input int l2);
        if (h1 == SHORT_SLOTS && l1 == LONG_SLOTS && h2 == SHORT_SLOTS && l2 == LONG_SLOTS)
            return K_ZERO;
        if (h1 == LONG_SLOTS && l1 == SHORT_SLOTS && h2 == LONG_SLOTS && l2 == SHORT_SLOTS)
            return K_ONE;
        if (h1 == SHORT_SLOTS && l1 == LONG_SLOTS && h2 == LONG_SLOTS && l2 == SHORT_SLOTS)
            return K_FLOAT;
        return K_BAD;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_inputs(input logic [15:0] a, input logic [3:0] d);
        @(posedge clk);
        #1;
        addr_code = a;
        data      = d;
    endtask

    // One high run and the low run after it, sampled at negedge
    task automatic read_pair(output int hi_a, output int lo_a, output int sync_cyc);
        int hi_c;
        int lo_c;
        int s_c;
        hi_c       = carry_hi;
        s_c        = carry_sync;
        lo_c       = 0;
        carry_hi   = 0;
        carry_sync = 0;
        while (hi_c == 0) begin                    // Only before the very first frame
            @(negedge clk);
            s_c += int'(sync === 1'b1);
            if (cod_o === 1'b1) hi_c = 1;
        end
        forever begin
            @(negedge clk);
            if (cod_o !== 1'b1) break;
            hi_c++;
            s_c += int'(sync === 1'b1);
        end
        lo_c = 1;                                  // Sample that ended the high run
        s_c += int'(sync === 1'b1);
        forever begin
            @(negedge clk);
            if (cod_o !== 1'b0) break;
            lo_c++;
            s_c += int'(sync === 1'b1);
        end
        carry_hi   = 1;                            // First high of the next symbol
        carry_sync = int'(sync === 1'b1);
        hi_a     = (hi_c % DIVIDER == 0) ? hi_c / DIVIDER : -1;
        lo_a     = (lo_c % DIVIDER == 0) ? lo_c / DIVIDER : -1;
        sync_cyc = s_c;
    endtask

    task automatic decode_symbol(output int kind, output int sync_cyc);
        int h1;
        int l1;
        int h2;
        int l2;
        int s1;
        int s2;
        read_pair(h1, l1, s1);
        if (h1 == SHORT_SLOTS && l1 == SYNC_SYMBOL_SLOTS - SHORT_SLOTS) begin
            kind     = K_SYNC;                     // Single 4 high, 124 low pair
            sync_cyc = s1;
        end else begin
            read_pair(h2, l2, s2);
            kind     = classify_pairs(h1, l1, h2, l2);
            sync_cyc = s1 + s2;
        end
    endtask

    // Decode thirteen symbols, optionally changing the inputs partway
    task automatic run_frame(input logic [15:0] exp_addr, input logic [3:0] exp_data,
                             input bit check, input int change_at,
                             input logic [15:0] new_addr, input logic [3:0] new_data);
        int kind;
        int sync_cyc;
        int exp_sync;
        for (int pos = 0; pos < SYMBOLS_PER_FRAME; pos++) begin
            if (pos == change_at) drive_inputs(new_addr, new_data);
            decode_symbol(kind, sync_cyc);
            exp_sync = (pos == SYMBOLS_PER_FRAME - 1) ? SHORT_SLOTS * DIVIDER : 0;
            if (check) begin
                check_value($sformatf("cod_o symbol %s", pos_name(pos)),
                            expected_kind(exp_addr, exp_data, pos), kind);
                check_value($sformatf("sync cycles in %s", pos_name(pos)), exp_sync, sync_cyc);
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [15:0] cur_addr;
        logic [15:0] nxt_addr;
        logic [3:0]  cur_data;
        logic [3:0]  nxt_data;
        bit          swap;
        bit          prev_swap;
        int          test_errors;
        string       label;
        clk        = 1'b0;
        reset      = 1'b1;
        addr_code  = TBL_ADDR[0];
        data       = TBL_DATA[0];
        carry_hi   = 0;
        carry_sync = 0;
        rng_state  = SEED;
        prev_swap  = 1'b0;

        // Line quiet in reset and up to the first tick
        test_errors = errors;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("cod_o in reset", 0, int'(cod_o));
            check_value("sync in reset", 0, int'(sync));
        end
        reset = 1'b0;
        repeat (DIVIDER) begin
            @(negedge clk);
            check_value("cod_o before first tick", 0, int'(cod_o));
            check_value("sync before first tick", 0, int'(sync));
        end
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("test 0 (reset) %s", (errors == test_errors) ? "passed" : "failed");

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (i < NUM_TABLE) begin
                cur_addr = TBL_ADDR[i];
                cur_data = TBL_DATA[i];
                swap     = TBL_SWAP[i] && (i + 1 < NUM_TABLE);
                label    = swap ? "mid-frame change" : "table";
            end else begin
                rnd       = xorshift32(rng_state);
                rng_state = rnd;
                cur_addr  = rnd[15:0];
                cur_data  = rnd[19:16];
                swap      = 1'b0;
                label     = "random";
            end
            nxt_addr = swap ? TBL_ADDR[i+1] : cur_addr;
            nxt_data = swap ? TBL_DATA[i+1] : cur_data;
            test_errors = errors;
            drive_inputs(cur_addr, cur_data);
            // First frame was latched earlier, it only counts after a mid-frame change
            run_frame(cur_addr, cur_data, prev_swap, -1, cur_addr, cur_data);
            run_frame(cur_addr, cur_data, 1'b1, swap ? SWAP_POS : -1, nxt_addr, nxt_data);
            prev_swap = swap;
            tests_run++;
            if (errors != test_errors) tests_failed++;
            $display("test %0d (%s) addr_code=%h data=%h %s", i + 1, label, cur_addr, cur_data,
                     (errors == test_errors) ? "passed" : "failed");
        end

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/pt2262_symbol_pkg.sv
design/pt2262_timing_pkg.sv
design/tick_divider.sv
design/address_interpreter.sv
design/symbol_shaper.sv
design/frame_sequencer.sv
design/pt2262_encoder_top.sv
bench/pt2262_encoder_props.sv
bench/pt2262_encoder_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := pt2262_encoder_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
